// ==== ioCsrDefines_defines.svh ====
`ifndef IO_CSR_DEFINES_SVH
`define IO_CSR_DEFINES_SVH

// bus widths
`define IO_ADDR_W 7
`define IO_DATA_W 32

// peripheral sizes
`define IO_GPIO_W 16
`define IO_SPI_BITS 8
// clk cycles per sck half period
`define IO_SPI_DIV 4
`define IO_LANES 4
`define IO_COUNT_W 32

// register map, word index taken from paddr[6:2]
`define IO_REG_IDX_W 5
`define IO_NUM_REGS 10
`define IO_NUM_CNT 5

`endif

// ==== ioCsrPkg.sv ====
`default_nettype none

`include "ioCsrDefines_defines.svh"

package ioCsrPkg;

    typedef logic [`IO_ADDR_W-1:0] csrAddrT;
    typedef logic [`IO_DATA_W-1:0] csrDataT;
    typedef logic [`IO_DATA_W/8-1:0] csrStrbT;
    typedef logic [`IO_GPIO_W-1:0] gpioT;
    typedef logic [`IO_SPI_BITS-1:0] spiByteT;
    typedef logic [`IO_LANES-1:0] laneVecT;
    typedef logic [`IO_COUNT_W-1:0] perfCountT;

    // word index of each register; anything above REG_CNT_BRANCH is unmapped
    typedef enum logic [`IO_REG_IDX_W-1:0] {
        REG_GPIO_OUT    = 5'd0,
        REG_GPIO_OE     = 5'd1,
        REG_GPIO_IN     = 5'd2,
        REG_SPI_DATA    = 5'd3,
        REG_SPI_STATUS  = 5'd4,
        REG_CNT_COMMIT  = 5'd5,
        REG_CNT_WB      = 5'd6,
        REG_CNT_FETCH   = 5'd7,
        REG_CNT_MISPRED = 5'd8,
        REG_CNT_BRANCH  = 5'd9
    } csrRegT;

    typedef enum logic [1:0] {SPI_IDLE, SPI_LEAD, SPI_TRAIL} spiStateT;

endpackage

`default_nettype wire

// ==== csrBus.sv ====
`default_nettype none

`include "ioCsrDefines_defines.svh"

module csrBus (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire ioCsrPkg::csrAddrT     paddr,
    input  wire ioCsrPkg::csrDataT     pwdata,
    input  wire ioCsrPkg::csrStrbT     pstrb,
    output logic                       pready,
    output logic                       pslverr,
    output ioCsrPkg::csrDataT          prdata,
    input  wire ioCsrPkg::gpioT        gpioOutReg,
    input  wire ioCsrPkg::gpioT        gpioOeReg,
    input  wire ioCsrPkg::gpioT        gpioInSync,
    input  wire logic                  spiBusy,
    input  wire ioCsrPkg::spiByteT     spiRx,
    input  wire ioCsrPkg::perfCountT   cntCommit,
    input  wire ioCsrPkg::perfCountT   cntWb,
    input  wire ioCsrPkg::perfCountT   cntFetch,
    input  wire ioCsrPkg::perfCountT   cntMispred,
    input  wire ioCsrPkg::perfCountT   cntBranch,
    output logic                       gpioWrOut,
    output logic                       gpioWrOe,
    output ioCsrPkg::csrDataT          wrData,
    output ioCsrPkg::csrStrbT          wrStrb,
    output logic                       spiStart,
    output ioCsrPkg::spiByteT          spiTx,
    output logic [`IO_NUM_CNT-1:0]     cntClear
);
    import ioCsrPkg::*;

    csrRegT regIdx;
    logic mapped;
    logic readOnly;
    logic stall;
    logic done;
    logic err;
    logic wrOk;
    csrDataT regVal;

    always_comb begin
        regIdx = csrRegT'(paddr[`IO_ADDR_W-1:2]);
        mapped = paddr[`IO_ADDR_W-1:2] < `IO_NUM_REGS;
        readOnly = (regIdx == REG_GPIO_IN) || (regIdx == REG_SPI_STATUS);
        // a new byte cannot be loaded while the shifter is running
        stall = pwrite && (regIdx == REG_SPI_DATA) && spiBusy;
        done = psel && penable && !stall;
        err = !mapped || (pwrite && readOnly);
        wrOk = done && pwrite && !err;
    end

    always_comb begin
        case (regIdx)
            REG_GPIO_OUT:    regVal = csrDataT'(gpioOutReg);
            REG_GPIO_OE:     regVal = csrDataT'(gpioOeReg);
            REG_GPIO_IN:     regVal = csrDataT'(gpioInSync);
            REG_SPI_DATA:    regVal = csrDataT'(spiRx);
            REG_SPI_STATUS:  regVal = csrDataT'(spiBusy);
            REG_CNT_COMMIT:  regVal = cntCommit;
            REG_CNT_WB:      regVal = cntWb;
            REG_CNT_FETCH:   regVal = cntFetch;
            REG_CNT_MISPRED: regVal = cntMispred;
            REG_CNT_BRANCH:  regVal = cntBranch;
            default:         regVal = '0;
        endcase
    end

    assign pready = done;
    assign pslverr = done && err;
    assign prdata = (done && !err) ? regVal : '0;

    // single-cycle strobes, only on a good completion
    assign gpioWrOut = wrOk && (regIdx == REG_GPIO_OUT);
    assign gpioWrOe = wrOk && (regIdx == REG_GPIO_OE);
    assign wrData = pwdata;
    assign wrStrb = pstrb;
    assign spiStart = wrOk && (regIdx == REG_SPI_DATA);
    assign spiTx = pwdata[`IO_SPI_BITS-1:0];

    // counter order matches the register map
    assign cntClear = {
        wrOk && (regIdx == REG_CNT_BRANCH),
        wrOk && (regIdx == REG_CNT_MISPRED),
        wrOk && (regIdx == REG_CNT_FETCH),
        wrOk && (regIdx == REG_CNT_WB),
        wrOk && (regIdx == REG_CNT_COMMIT)
    };

    // access phase only ever follows a selected setup phase
    apbEnableNeedsSel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

`default_nettype wire

// ==== gpioPort.sv ====
`default_nettype none

module gpioPort (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              gpioWrOut,
    input  wire logic              gpioWrOe,
    input  wire ioCsrPkg::csrDataT wrData,
    input  wire ioCsrPkg::csrStrbT wrStrb,
    input  wire ioCsrPkg::gpioT    gpioIn,
    output ioCsrPkg::gpioT         gpioOut,
    output ioCsrPkg::gpioT         gpioOe,
    output ioCsrPkg::gpioT         gpioInSync
);
    import ioCsrPkg::*;

    gpioT syncStage;

    // replace only the strobed bytes of a pin register
    function automatic gpioT mergeBytes(gpioT old, csrDataT data, csrStrbT strb);
        gpioT res;
        res = old;
        if (strb[0]) res[7:0] = data[7:0];
        if (strb[1]) res[15:8] = data[15:8];
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            gpioOut <= '0;
            gpioOe <= '0;
        end else begin
            if (gpioWrOut) gpioOut <= mergeBytes(gpioOut, wrData, wrStrb);
            if (gpioWrOe) gpioOe <= mergeBytes(gpioOe, wrData, wrStrb);
        end
    end

    // two flops against metastability on the pins
    always_ff @(posedge clk) begin
        syncStage <= gpioIn;
        gpioInSync <= syncStage;
    end

endmodule

`default_nettype wire

// ==== spiMaster.sv ====
`default_nettype none

`include "ioCsrDefines_defines.svh"

module spiMaster (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              spiStart,
    input  wire ioCsrPkg::spiByteT spiTx,
    input  wire logic              spiMiso,
    output logic                   spiBusy,
    output ioCsrPkg::spiByteT      spiRx,
    output logic                   spiClk,
    output logic                   spiMosi
);
    import ioCsrPkg::*;

    localparam int DivW = $clog2(`IO_SPI_DIV);
    localparam int BitW = $clog2(`IO_SPI_BITS);

    spiStateT state;
    logic [DivW-1:0] divCnt;
    logic [BitW-1:0] bitCnt;
    // tx bits leave at the top while rx bits enter at the bottom
    spiByteT shiftReg;
    logic halfDone;

    assign halfDone = (divCnt == DivW'(`IO_SPI_DIV - 1));
    assign spiBusy = (state != SPI_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SPI_IDLE;
            divCnt <= '0;
            bitCnt <= '0;
            spiClk <= 1'b0;
            spiMosi <= 1'b0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (spiStart) begin
                        state <= SPI_LEAD;
                        divCnt <= '0;
                        bitCnt <= '0;
                        spiMosi <= spiTx[`IO_SPI_BITS-1];
                    end
                end
                SPI_LEAD: begin
                    divCnt <= divCnt + 1'b1;
                    if (halfDone) begin
                        // rising sck, sample miso here
                        state <= SPI_TRAIL;
                        divCnt <= '0;
                        spiClk <= 1'b1;
                    end
                end
                SPI_TRAIL: begin
                    divCnt <= divCnt + 1'b1;
                    if (halfDone) begin
                        divCnt <= '0;
                        spiClk <= 1'b0;
                        if (bitCnt == BitW'(`IO_SPI_BITS - 1)) begin
                            state <= SPI_IDLE;
                            spiMosi <= 1'b0;
                        end else begin
                            state <= SPI_LEAD;
                            bitCnt <= bitCnt + 1'b1;
                            spiMosi <= shiftReg[`IO_SPI_BITS-1];
                        end
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // data path, loaded on start and shifted on each rising sck
    always_ff @(posedge clk) begin
        if (state == SPI_IDLE && spiStart) begin
            shiftReg <= spiTx;
        end else if (state == SPI_LEAD && halfDone) begin
            shiftReg <= {shiftReg[`IO_SPI_BITS-2:0], spiMiso};
        end
        if (state == SPI_TRAIL && halfDone && bitCnt == BitW'(`IO_SPI_BITS - 1)) begin
            spiRx <= shiftReg;
        end
    end

    // the bus must hold off a new byte until the shifter is idle
    noStartWhileBusy: assert property (@(posedge clk) disable iff (rst) spiStart |-> !spiBusy);

endmodule

`default_nettype wire

// ==== perfCounters.sv ====
`default_nettype none

`include "ioCsrDefines_defines.svh"

module perfCounters (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire ioCsrPkg::laneVecT      commitValid,
    input  wire ioCsrPkg::laneVecT      wbValid,
    input  wire ioCsrPkg::laneVecT      fetchValid,
    input  wire logic                   branchMispred,
    input  wire logic                   branchCommitted,
    input  wire logic [`IO_NUM_CNT-1:0] cntClear,
    output ioCsrPkg::perfCountT         cntCommit,
    output ioCsrPkg::perfCountT         cntWb,
    output ioCsrPkg::perfCountT         cntFetch,
    output ioCsrPkg::perfCountT         cntMispred,
    output ioCsrPkg::perfCountT         cntBranch
);
    import ioCsrPkg::*;

    perfCountT counts [`IO_NUM_CNT];
    perfCountT incr [`IO_NUM_CNT];

    // number of lanes that carried an event this cycle
    function automatic perfCountT popCount(laneVecT lanes);
        perfCountT sum;
        sum = '0;
        for (int i = 0; i < `IO_LANES; i++) begin
            sum = sum + perfCountT'(lanes[i]);
        end
        return sum;
    endfunction

    // same order as cntClear and the register map
    always_comb begin
        incr[0] = popCount(commitValid);
        incr[1] = popCount(wbValid);
        incr[2] = popCount(fetchValid);
        incr[3] = perfCountT'(branchMispred);
        incr[4] = perfCountT'(branchCommitted);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `IO_NUM_CNT; i++) begin
            if (rst) begin
                counts[i] <= '0;
            end else if (cntClear[i]) begin
                // events on the clearing edge are dropped
                counts[i] <= '0;
            end else begin
                counts[i] <= counts[i] + incr[i];
            end
        end
    end

    assign cntCommit = counts[0];
    assign cntWb = counts[1];
    assign cntFetch = counts[2];
    assign cntMispred = counts[3];
    assign cntBranch = counts[4];

endmodule

`default_nettype wire

// ==== ioCsrTop.sv ====
`default_nettype none

`include "ioCsrDefines_defines.svh"

module ioCsrTop (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire ioCsrPkg::csrAddrT   paddr,
    input  wire ioCsrPkg::csrDataT   pwdata,
    input  wire ioCsrPkg::csrStrbT   pstrb,
    output logic                     pready,
    output logic                     pslverr,
    output ioCsrPkg::csrDataT        prdata,
    input  wire ioCsrPkg::gpioT      gpioIn,
    output ioCsrPkg::gpioT           gpioOut,
    output ioCsrPkg::gpioT           gpioOe,
    output logic                     spiClk,
    output logic                     spiMosi,
    input  wire logic                spiMiso,
    input  wire ioCsrPkg::laneVecT   commitValid,
    input  wire ioCsrPkg::laneVecT   wbValid,
    input  wire ioCsrPkg::laneVecT   fetchValid,
    input  wire logic                branchMispred,
    input  wire logic                branchCommitted
);
    import ioCsrPkg::*;

    // bus side strobes
    logic gpioWrOut;
    logic gpioWrOe;
    csrDataT wrData;
    csrStrbT wrStrb;
    logic spiStart;
    spiByteT spiTx;
    logic [`IO_NUM_CNT-1:0] cntClear;

    // peripheral state back to the read mux
    gpioT gpioInSync;
    logic spiBusy;
    spiByteT spiRx;
    perfCountT cntCommit;
    perfCountT cntWb;
    perfCountT cntFetch;
    perfCountT cntMispred;
    perfCountT cntBranch;

    csrBus bus (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .pslverr(pslverr), .prdata(prdata),
        .gpioOutReg(gpioOut), .gpioOeReg(gpioOe), .gpioInSync(gpioInSync),
        .spiBusy(spiBusy), .spiRx(spiRx),
        .cntCommit(cntCommit), .cntWb(cntWb), .cntFetch(cntFetch),
        .cntMispred(cntMispred), .cntBranch(cntBranch),
        .gpioWrOut(gpioWrOut), .gpioWrOe(gpioWrOe),
        .wrData(wrData), .wrStrb(wrStrb),
        .spiStart(spiStart), .spiTx(spiTx), .cntClear(cntClear)
    );

    gpioPort gpio (
        .clk(clk), .rst(rst),
        .gpioWrOut(gpioWrOut), .gpioWrOe(gpioWrOe),
        .wrData(wrData), .wrStrb(wrStrb), .gpioIn(gpioIn),
        .gpioOut(gpioOut), .gpioOe(gpioOe), .gpioInSync(gpioInSync)
    );

    spiMaster spi (
        .clk(clk), .rst(rst),
        .spiStart(spiStart), .spiTx(spiTx), .spiMiso(spiMiso),
        .spiBusy(spiBusy), .spiRx(spiRx), .spiClk(spiClk), .spiMosi(spiMosi)
    );

    perfCounters perf (
        .clk(clk), .rst(rst),
        .commitValid(commitValid), .wbValid(wbValid), .fetchValid(fetchValid),
        .branchMispred(branchMispred), .branchCommitted(branchCommitted),
        .cntClear(cntClear),
        .cntCommit(cntCommit), .cntWb(cntWb), .cntFetch(cntFetch),
        .cntMispred(cntMispred), .cntBranch(cntBranch)
    );

endmodule

`default_nettype wire

// ==== ioCsrTb.sv ====
`default_nettype none

`include "ioCsrDefines_defines.svh"

module ioCsrTb;
    import ioCsrPkg::*;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_PINS, OP_EVENTS, OP_SPIWAIT, OP_OUTCHK, OP_CNTREAD, OP_STALLWR
    } opT;

    localparam int MaxSteps = 64;
    localparam int BusTimeout = 200;
    localparam int PollLimit = 100;

    logic clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    csrAddrT paddr;
    csrDataT pwdata;
    csrStrbT pstrb;
    logic pready;
    logic pslverr;
    csrDataT prdata;
    gpioT gpioIn;
    gpioT gpioOut;
    gpioT gpioOe;
    logic spiClk;
    logic spiMosi;
    laneVecT commitValid;
    laneVecT wbValid;
    laneVecT fetchValid;
    logic branchMispred;
    logic branchCommitted;

    // stimulus table, one entry per test
    opT stepOp [MaxSteps];
    logic [4:0] stepIdx [MaxSteps];
    csrDataT stepData [MaxSteps];
    csrStrbT stepStrb [MaxSteps];
    csrDataT stepExp [MaxSteps];
    logic stepErr [MaxSteps];
    int numSteps;

    // event totals seen by the testbench, in register map order
    perfCountT expCount [`IO_NUM_CNT];
    logic [31:0] lcgState;
    int errCount;
    int stepFails;
    int failedTests;
    int stepsRun;
    logic timedOut;
    gpioT outShadow;
    gpioT oeShadow;
    int sckRises;
    int expSckRises;

    // miso looped back from mosi
    ioCsrTop DUT (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .pslverr(pslverr), .prdata(prdata),
        .gpioIn(gpioIn), .gpioOut(gpioOut), .gpioOe(gpioOe),
        .spiClk(spiClk), .spiMosi(spiMosi), .spiMiso(spiMosi),
        .commitValid(commitValid), .wbValid(wbValid), .fetchValid(fetchValid),
        .branchMispred(branchMispred), .branchCommitted(branchCommitted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one rising sck per shifted bit
    always @(posedge spiClk) begin
        sckRises++;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkData(input string sig, input csrDataT got, input csrDataT exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, sig, got, exp);
            errCount++;
            stepFails++;
        end
    endtask

    task automatic checkPins(input string sig, input gpioT got, input gpioT exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, sig, got, exp);
            errCount++;
            stepFails++;
        end
    endtask

    task automatic checkFlag(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, sig, got, exp);
            errCount++;
            stepFails++;
        end
    endtask

    task automatic addStep(input opT op, input logic [4:0] idx, input csrDataT data,
                           input csrStrbT strb, input csrDataT exp, input logic err);
        stepOp[numSteps] = op;
        stepIdx[numSteps] = idx;
        stepData[numSteps] = data;
        stepStrb[numSteps] = strb;
        stepExp[numSteps] = exp;
        stepErr[numSteps] = err;
        numSteps++;
    endtask

    // only the strobed low and high bytes take the new data
    task automatic addGpioWrite(input csrRegT regSel, input csrStrbT strb, inout gpioT shadow);
        csrDataT d;
        d = nextRand();
        if (strb[0]) begin
            shadow[7:0] = d[7:0];
        end
        if (strb[1]) begin
            shadow[15:8] = d[15:8];
        end
        addStep(OP_WRITE, regSel, d, strb, '0, 1'b0);
        addStep(OP_OUTCHK, regSel, '0, '0, csrDataT'(shadow), 1'b0);
        addStep(OP_READ, regSel, '0, '0, csrDataT'(shadow), 1'b0);
    endtask

    // one APB transfer, waits for pready in the access phase
    task automatic apbXfer(input logic wr, input logic [4:0] idx, input csrDataT data,
                           input csrStrbT strb, output csrDataT rdata, output logic err,
                           output int waited);
        waited = 0;
        rdata = '0;
        err = 1'b0;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= {idx, 2'b00};
        pwdata <= data;
        pstrb <= strb;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waited < BusTimeout) begin
            waited++;
            @(negedge clk);
        end
        if (pready) begin
            rdata = prdata;
            err = pslverr;
        end else begin
            $display("timeout: pready stayed low for %0d cycles on index %0d", BusTimeout, idx);
            timedOut = 1'b1;
        end
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic runStep(input int i);
        csrDataT rdata;
        logic err;
        int waited;
        int polls;
        logic [31:0] r;
        laneVecT c;
        laneVecT w;
        laneVecT f;
        logic m;
        logic b;
        case (stepOp[i])
            OP_WRITE, OP_STALLWR: begin
                apbXfer(1'b1, stepIdx[i], stepData[i], stepStrb[i], rdata, err, waited);
                checkFlag("pslverr", err, stepErr[i]);
                if (stepErr[i]) begin
                    checkData("prdata", rdata, '0);
                end
                if (stepOp[i] == OP_STALLWR) begin
                    checkFlag("pready held low", waited > 0, 1'b1);
                end
                // a good write to a counter clears it
                if (!stepErr[i] && stepIdx[i] >= REG_CNT_COMMIT
                        && stepIdx[i] <= REG_CNT_BRANCH) begin
                    expCount[int'(stepIdx[i]) - 5] = '0;
                end
                // a good data write shifts out one byte
                if (!stepErr[i] && stepIdx[i] == REG_SPI_DATA) begin
                    expSckRises += `IO_SPI_BITS;
                end
            end
            OP_READ: begin
                apbXfer(1'b0, stepIdx[i], '0, '0, rdata, err, waited);
                checkFlag("pslverr", err, stepErr[i]);
                checkData("prdata", rdata, stepExp[i]);
            end
            OP_CNTREAD: begin
                apbXfer(1'b0, stepIdx[i], '0, '0, rdata, err, waited);
                checkFlag("pslverr", err, 1'b0);
                checkData("prdata", rdata, expCount[int'(stepIdx[i]) - 5]);
            end
            OP_PINS: begin
                @(posedge clk);
                gpioIn <= stepData[i][15:0];
            end
            OP_EVENTS: begin
                for (int k = 0; k < int'(stepData[i]); k++) begin
                    r = nextRand();
                    c = r[3:0];
                    w = r[7:4];
                    f = r[11:8];
                    m = r[12];
                    b = r[13];
                    @(posedge clk);
                    commitValid <= c;
                    wbValid <= w;
                    fetchValid <= f;
                    branchMispred <= m;
                    branchCommitted <= b;
                    expCount[0] = expCount[0] + perfCountT'($countones(c));
                    expCount[1] = expCount[1] + perfCountT'($countones(w));
                    expCount[2] = expCount[2] + perfCountT'($countones(f));
                    expCount[3] = expCount[3] + perfCountT'(m);
                    expCount[4] = expCount[4] + perfCountT'(b);
                end
                @(posedge clk);
                commitValid <= '0;
                wbValid <= '0;
                fetchValid <= '0;
                branchMispred <= 1'b0;
                branchCommitted <= 1'b0;
            end
            OP_SPIWAIT: begin
                polls = 0;
                rdata = 32'd1;
                while (rdata[0] && polls < PollLimit && !timedOut) begin
                    apbXfer(1'b0, REG_SPI_STATUS, '0, '0, rdata, err, waited);
                    polls++;
                end
                if (rdata[0] && !timedOut) begin
                    $display("timeout: SPI still busy after %0d status reads", PollLimit);
                    timedOut = 1'b1;
                end else if (!timedOut) begin
                    // idle sck is low and every bit so far gave one rising edge
                    @(negedge clk);
                    checkFlag("spiClk", spiClk, 1'b0);
                    checkData("spiClk rising edges", csrDataT'(sckRises),
                              csrDataT'(expSckRises));
                end
            end
            OP_OUTCHK: begin
                @(negedge clk);
                if (stepIdx[i] == REG_GPIO_OUT) begin
                    checkPins("gpioOut", gpioOut, stepExp[i][15:0]);
                end else begin
                    checkPins("gpioOe", gpioOe, stepExp[i][15:0]);
                end
            end
            default: begin
                $display("unknown operation in table entry %0d", i);
                stepFails++;
                errCount++;
            end
        endcase
    endtask

    task automatic buildTable();
        logic [31:0] r;
        gpioT pins;
        spiByteT b1;
        spiByteT b2;
        // GPIO output and enable under mixed strobes
        addGpioWrite(REG_GPIO_OUT, 4'b0011, outShadow);
        addGpioWrite(REG_GPIO_OUT, 4'b0001, outShadow);
        addGpioWrite(REG_GPIO_OUT, 4'b0010, outShadow);
        addGpioWrite(REG_GPIO_OUT, 4'b1100, outShadow);
        addGpioWrite(REG_GPIO_OE, 4'b0010, oeShadow);
        addGpioWrite(REG_GPIO_OE, 4'b1111, oeShadow);
        addGpioWrite(REG_GPIO_OE, 4'b0001, oeShadow);
        // input pins, then a rejected write to the read-only register
        r = nextRand();
        pins = r[15:0];
        addStep(OP_PINS, 5'd0, csrDataT'(pins), '0, '0, 1'b0);
        addStep(OP_READ, REG_GPIO_IN, '0, '0, csrDataT'(pins), 1'b0);
        addStep(OP_WRITE, REG_GPIO_IN, csrDataT'(~pins), 4'hF, '0, 1'b1);
        addStep(OP_READ, REG_GPIO_IN, '0, '0, csrDataT'(pins), 1'b0);
        // SPI loopback and back-pressure
        r = nextRand();
        b1 = r[7:0];
        b2 = r[15:8];
        // stalled byte differs from every earlier one
        if (b2 == b1) begin
            b2 = ~b1;
        end
        addStep(OP_WRITE, REG_SPI_DATA, csrDataT'(b1), 4'h1, '0, 1'b0);
        addStep(OP_READ, REG_SPI_STATUS, '0, '0, 32'd1, 1'b0);
        addStep(OP_SPIWAIT, 5'd0, '0, '0, '0, 1'b0);
        addStep(OP_READ, REG_SPI_DATA, '0, '0, csrDataT'(b1), 1'b0);
        addStep(OP_WRITE, REG_SPI_DATA, csrDataT'(b1), 4'h1, '0, 1'b0);
        addStep(OP_STALLWR, REG_SPI_DATA, csrDataT'(b2), 4'h1, '0, 1'b0);
        addStep(OP_SPIWAIT, 5'd0, '0, '0, '0, 1'b0);
        addStep(OP_READ, REG_SPI_DATA, '0, '0, csrDataT'(b2), 1'b0);
        addStep(OP_WRITE, REG_SPI_STATUS, 32'd0, 4'hF, '0, 1'b1);
        // event counters with clears in between
        addStep(OP_EVENTS, 5'd0, 32'd40, '0, '0, 1'b0);
        for (int k = 5; k < 10; k++) begin
            addStep(OP_CNTREAD, 5'(k), '0, '0, '0, 1'b0);
        end
        addStep(OP_WRITE, REG_CNT_WB, 32'hffff_ffff, 4'hF, '0, 1'b0);
        addStep(OP_CNTREAD, REG_CNT_WB, '0, '0, '0, 1'b0);
        addStep(OP_WRITE, REG_CNT_BRANCH, 32'd0, 4'hF, '0, 1'b0);
        addStep(OP_EVENTS, 5'd0, 32'd25, '0, '0, 1'b0);
        for (int k = 5; k < 10; k++) begin
            addStep(OP_CNTREAD, 5'(k), '0, '0, '0, 1'b0);
        end
        // unmapped indices
        addStep(OP_READ, 5'd10, '0, '0, '0, 1'b1);
        addStep(OP_WRITE, 5'd31, 32'h1234_5678, 4'hF, '0, 1'b1);
        addStep(OP_READ, 5'd17, '0, '0, '0, 1'b1);
    endtask

    initial begin
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pstrb = '0;
        gpioIn = '0;
        commitValid = '0;
        wbValid = '0;
        fetchValid = '0;
        branchMispred = 1'b0;
        branchCommitted = 1'b0;
        errCount = 0;
        failedTests = 0;
        stepsRun = 0;
        numSteps = 0;
        timedOut = 1'b0;
        outShadow = '0;
        oeShadow = '0;
        sckRises = 0;
        expSckRises = 0;
        lcgState = 32'h764c3f97;
        for (int k = 0; k < `IO_NUM_CNT; k++) begin
            expCount[k] = '0;
        end
        buildTable();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < numSteps && !timedOut; i++) begin
            stepFails = 0;
            runStep(i);
            stepsRun++;
            if (stepFails != 0 || timedOut) begin
                failedTests++;
                $display("test %0d %s failed", i, stepOp[i].name());
            end else begin
                $display("test %0d %s ok", i, stepOp[i].name());
            end
        end
        $display("tests run %0d of %0d, tests failed %0d, check errors %0d",
                 stepsRun, numSteps, failedTests, errCount);
        if (errCount == 0 && failedTests == 0 && !timedOut) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ioCsr.f ====
+incdir+.
ioCsrPkg.sv
csrBus.sv
gpioPort.sv
spiMaster.sv
perfCounters.sv
ioCsrTop.sv
ioCsrTb.sv

// ==== runSim.sh ====
#!/bin/sh
# compile and run the ioCsr testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ioCsr.f --top-module ioCsrTb -o simIoCsr
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simIoCsr > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
